// ==== dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

	// one data word
	typedef logic [31:0] word_t;

	// byte-lane write enables, bit i enables byte i
	typedef logic [3:0] strobe_t;

	// controller word address, covers the RAM only
	typedef logic [9:0] con_addr_t;

	// controller request
	// zero strobe reads, legal strobe writes, anything else is dropped
	typedef struct packed {
		strobe_t   we;
		con_addr_t addr;
		word_t     data;
	} con_req_t;

	// core-side I/O word addresses
	localparam logic [10:0] IO_BTN = 11'h400;
	localparam logic [10:0] IO_SW  = 11'h401;
	localparam logic [10:0] IO_LED = 11'h402;

	// store word, store half, store byte patterns only
	function automatic logic strobe_legal(input strobe_t s);
		case (s)
			4'b1111, 4'b0011, 4'b1100: return 1'b1;
			4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// replace the enabled bytes of old_w with those of new_w
	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
			input strobe_t s);
		word_t w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (s[i]) begin
				w[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return w;
	endfunction

endpackage

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       nrst,
	input  logic                       push,
	input  T                           wdata,
	input  logic                       pop,
	output T                           rdata,
	output logic                       empty,
	output logic                       full,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// storage, no reset
	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// count moves only when push and pop differ
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// show-ahead read of the oldest entry
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (!nrst) pop |-> !empty)
		else $error("sync_fifo: pop while empty");
	a_no_overflow: assert property (@(posedge clk) disable iff (!nrst) push |-> !full)
		else $error("sync_fifo: push while full");

endmodule

`default_nettype wire

// ==== dual_port_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram import dmem_pkg::*; #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,

	// port A, core side
	input  strobe_t           a_we,
	input  logic [ADDR_W-1:0] a_addr,
	input  word_t             a_wdata,
	output word_t             a_rdata,

	// port B, controller side
	input  strobe_t           b_we,
	input  logic [ADDR_W-1:0] b_addr,
	input  word_t             b_wdata,
	output word_t             b_rdata
);

	localparam int WORDS = 2 ** ADDR_W;

	// contents survive reset
	word_t mem [WORDS];

	// one process for both ports
	// port A is written last so it wins a same-word collision
	always_ff @(posedge clk) begin
		if (b_we != '0) begin
			mem[b_addr] <= merge_bytes(mem[b_addr], b_wdata, b_we);
		end
		if (a_we != '0) begin
			mem[a_addr] <= merge_bytes(mem[a_addr], a_wdata, a_we);
		end
	end

	// read-first on both ports
	// old word comes out when a port reads and writes the same address
	always_ff @(posedge clk) begin
		a_rdata <= mem[a_addr];
	end

	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

	// core and controller writing one word at the same edge
	// core data is kept, controller data is lost
	a_write_collision: assert property (@(posedge clk)
		!((a_we != '0) && (b_we != '0) && (a_addr == b_addr)))
		else $warning("dual_port_ram: both ports wrote word %0h, port A kept", a_addr);

endmodule

`default_nettype wire

// ==== fpga_io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpga_io_regs import dmem_pkg::*; (
	input  logic       clk,
	input  logic       nrst,

	// board pins
	input  logic [3:0] btn,
	input  logic [2:0] sw,

	// core write to the LED word, already decoded
	input  strobe_t    led_we,
	input  word_t      wdata,

	// 0 buttons, 1 switches, 2 LED
	input  logic [1:0] sel,
	output word_t      rdata,
	output logic [3:0] led
);

	word_t btn_q;
	word_t sw_q;
	word_t led_q;

	// sample the pins every edge, zero-extended
	always_ff @(posedge clk) begin
		if (!nrst) begin
			btn_q <= '0;
			sw_q <= '0;
		end else begin
			btn_q <= {28'h0, btn};
			sw_q <= {29'h0, sw};
		end
	end

	// LED word, byte-lane writes
	always_ff @(posedge clk) begin
		if (!nrst) begin
			led_q <= '0;
		end else if (led_we != '0) begin
			led_q <= merge_bytes(led_q, wdata, led_we);
		end
	end

	assign led = led_q[3:0];

	// registered read, same latency as the RAM
	// LED read sees the word before a write at the same edge
	always_ff @(posedge clk) begin
		case (sel)
			2'd0: rdata <= btn_q;
			2'd1: rdata <= sw_q;
			2'd2: rdata <= led_q;
			default: rdata <= '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== datamem.sv ====
`timescale 1ns/1ps
`default_nettype none

module datamem import dmem_pkg::*; (
	input  logic        clk,
	input  logic        nrst,

	// core request, fixed timing
	input  strobe_t     dm_write,
	input  logic [10:0] data_addr,
	input  word_t       data_in,
	output word_t       data_out,

	// board I/O
	input  logic [3:0]  btn,
	input  logic [2:0]  sw,
	output logic [3:0]  led,

	// RAM port A
	output strobe_t     ram_we,
	output con_addr_t   ram_addr,
	output word_t       ram_wdata,
	input  word_t       ram_rdata
);

	// which source answers the read, one cycle late
	typedef enum logic [1:0] {
		SRC_ZERO,
		SRC_RAM,
		SRC_IO
	} src_t;

	strobe_t we_legal;
	strobe_t led_we;
	logic    is_ram;
	logic    is_io;
	word_t   io_rdata;
	src_t    src_q;

	// illegal patterns write nothing anywhere
	assign we_legal = strobe_legal(dm_write) ? dm_write : '0;

	// 0x000-0x3ff RAM, 0x400-0x402 I/O, rest unmapped
	assign is_ram = !data_addr[10];
	assign is_io = (data_addr == IO_BTN) || (data_addr == IO_SW) || (data_addr == IO_LED);

	assign ram_we = is_ram ? we_legal : '0;
	assign ram_addr = data_addr[9:0];
	assign ram_wdata = data_in;

	// only the LED word is writable
	assign led_we = (data_addr == IO_LED) ? we_legal : '0;

	fpga_io_regs fpga_io_regs_i (
		.clk    (clk),
		.nrst   (nrst),
		.btn    (btn),
		.sw     (sw),
		.led_we (led_we),
		.wdata  (data_in),
		.sel    (data_addr[1:0]),
		.rdata  (io_rdata),
		.led    (led)
	);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			src_q <= SRC_ZERO;
		end else if (is_ram) begin
			src_q <= SRC_RAM;
		end else if (is_io) begin
			src_q <= SRC_IO;
		end else begin
			src_q <= SRC_ZERO;
		end
	end

	// unmapped reads give zero
	always_comb begin
		case (src_q)
			SRC_RAM: data_out = ram_rdata;
			SRC_IO: data_out = io_rdata;
			default: data_out = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== con_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module con_port import dmem_pkg::*; #(
	parameter int REQ_DEPTH = 4,
	parameter int RSP_DEPTH = 4
) (
	input  logic      clk,
	input  logic      nrst,

	// requests, credited by the requester
	input  logic      con_req_valid,
	input  con_req_t  con_req,
	output logic      con_req_credit,

	// read responses, credited by the consumer
	output logic      con_rsp_valid,
	output word_t     con_rsp,
	input  logic      con_rsp_credit,

	// RAM port B
	output strobe_t   ram_we,
	output con_addr_t ram_addr,
	output word_t     ram_wdata,
	input  word_t     ram_rdata
);

	localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);

	con_req_t             req_head;
	logic                 req_empty;
	logic                 req_full;
	logic                 req_pop;
	logic                 head_read;
	logic                 rsp_room;
	logic                 rd_q;
	logic                 rsp_empty;
	logic                 rsp_pop;
	logic [RSP_CNT_W-1:0] rsp_count;
	logic [RSP_CNT_W-1:0] rsp_credits;

	sync_fifo #(.T(con_req_t), .DEPTH(REQ_DEPTH)) req_fifo_i (
		.clk   (clk),
		.nrst  (nrst),
		.push  (con_req_valid),
		.wdata (con_req),
		.pop   (req_pop),
		.rdata (req_head),
		.empty (req_empty),
		.full  (req_full),
		.count ()
	);

	// zero strobe is a read
	assign head_read = (req_head.we == '0);

	// a read needs a response slot, counting the one still in the RAM
	assign rsp_room = (int'(rsp_count) + int'(rd_q)) < RSP_DEPTH;
	assign req_pop = !req_empty && (!head_read || rsp_room);

	// port B straight from the FIFO head
	// illegal strobes pop but write nothing
	assign ram_addr = req_head.addr;
	assign ram_wdata = req_head.data;
	assign ram_we = (req_pop && strobe_legal(req_head.we)) ? req_head.we : '0;

	// rd_q marks RAM data valid on the next cycle
	always_ff @(posedge clk) begin
		if (!nrst) begin
			rd_q <= 1'b0;
			con_req_credit <= 1'b0;
		end else begin
			rd_q <= req_pop && head_read;
			con_req_credit <= req_pop;
		end
	end

	sync_fifo #(.T(word_t), .DEPTH(RSP_DEPTH)) rsp_fifo_i (
		.clk   (clk),
		.nrst  (nrst),
		.push  (rd_q),
		.wdata (ram_rdata),
		.pop   (rsp_pop),
		.rdata (con_rsp),
		.empty (rsp_empty),
		.full  (),
		.count (rsp_count)
	);

	// present a response only while the consumer has room
	assign con_rsp_valid = !rsp_empty && (rsp_credits != '0);
	assign rsp_pop = con_rsp_valid;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			rsp_credits <= RSP_CNT_W'(RSP_DEPTH);
		end else begin
			case ({con_rsp_credit, rsp_pop})
				2'b10: rsp_credits <= rsp_credits + 1'b1;
				2'b01: rsp_credits <= rsp_credits - 1'b1;
				default: rsp_credits <= rsp_credits;
			endcase
		end
	end

	// requester sent with no credit left
	a_req_credit: assert property (@(posedge clk) disable iff (!nrst)
		con_req_valid |-> !req_full)
		else $error("con_port: request sent without a credit");

	// consumer returned more credits than responses it took
	a_rsp_credit_max: assert property (@(posedge clk) disable iff (!nrst)
		rsp_credits <= RSP_CNT_W'(RSP_DEPTH))
		else $error("con_port: response credits above RSP_DEPTH");

endmodule

`default_nettype wire

// ==== dmem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys import dmem_pkg::*; #(
	parameter int RAM_ADDR_W = 10,
	parameter int REQ_DEPTH = 4,
	parameter int RSP_DEPTH = 4
) (
	input  logic        clk,
	input  logic        nrst,

	// core data port
	input  strobe_t     dm_write,
	input  logic [10:0] data_addr,
	input  word_t       data_in,
	output word_t       data_out,

	// board pins
	input  logic [3:0]  btn,
	input  logic [2:0]  sw,
	output logic [3:0]  led,

	// protocol controller
	input  logic        con_req_valid,
	input  con_req_t    con_req,
	output logic        con_req_credit,
	output logic        con_rsp_valid,
	output word_t       con_rsp,
	input  logic        con_rsp_credit
);

	// port A core side, port B controller side
	strobe_t   a_we;
	con_addr_t a_addr;
	word_t     a_wdata;
	word_t     a_rdata;
	strobe_t   b_we;
	con_addr_t b_addr;
	word_t     b_wdata;
	word_t     b_rdata;

	// both ports address the RAM with con_addr_t
	if (RAM_ADDR_W != $bits(con_addr_t)) begin : g_addr_w_check
		$error("dmem_subsys: RAM_ADDR_W must equal the controller address width");
	end

	datamem datamem_i (
		.clk       (clk),
		.nrst      (nrst),
		.dm_write  (dm_write),
		.data_addr (data_addr),
		.data_in   (data_in),
		.data_out  (data_out),
		.btn       (btn),
		.sw        (sw),
		.led       (led),
		.ram_we    (a_we),
		.ram_addr  (a_addr),
		.ram_wdata (a_wdata),
		.ram_rdata (a_rdata)
	);

	con_port #(.REQ_DEPTH(REQ_DEPTH), .RSP_DEPTH(RSP_DEPTH)) con_port_i (
		.clk            (clk),
		.nrst           (nrst),
		.con_req_valid  (con_req_valid),
		.con_req        (con_req),
		.con_req_credit (con_req_credit),
		.con_rsp_valid  (con_rsp_valid),
		.con_rsp        (con_rsp),
		.con_rsp_credit (con_rsp_credit),
		.ram_we         (b_we),
		.ram_addr       (b_addr),
		.ram_wdata      (b_wdata),
		.ram_rdata      (b_rdata)
	);

	dual_port_ram #(.ADDR_W(RAM_ADDR_W)) dual_port_ram_i (
		.clk     (clk),
		.a_we    (a_we),
		.a_addr  (a_addr),
		.a_wdata (a_wdata),
		.a_rdata (a_rdata),
		.b_we    (b_we),
		.b_addr  (b_addr),
		.b_wdata (b_wdata),
		.b_rdata (b_rdata)
	);

endmodule

`default_nettype wire

// ==== tb_dmem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_subsys import dmem_pkg::*; ();

	localparam int REQ_DEPTH = 4;
	localparam int RSP_DEPTH = 4;
	localparam int WAIT_LIMIT = 200;

	// step codes, one per op word in the case file
	localparam int OP_CW = 0;
	localparam int OP_CR = 1;
	localparam int OP_NW = 2;
	localparam int OP_NR = 3;
	localparam int OP_IO = 4;
	localparam int OP_HOLD = 5;
	localparam int OP_REL = 6;
	localparam int OP_QUIET = 7;
	localparam int OP_SYNC = 8;
	localparam int OP_CRED = 9;

	typedef struct packed {
		logic [3:0]  op;
		logic [10:0] addr;
		strobe_t     strb;
		word_t       data;
		word_t       exp;
	} step_t;

	logic        clk;
	logic        nrst;
	strobe_t     dm_write;
	logic [10:0] data_addr;
	word_t       data_in;
	word_t       data_out;
	logic [3:0]  btn;
	logic [2:0]  sw;
	logic [3:0]  led;
	logic        con_req_valid;
	con_req_t    con_req;
	logic        con_req_credit;
	logic        con_rsp_valid;
	word_t       con_rsp;
	logic        con_rsp_credit;

	step_t  steps[$];
	string  step_ops[$];
	word_t  exp_rsp[$];
	int     req_credits;
	int     owed;
	logic   hold_credits;
	int     n_pass;
	int     n_fail;
	integer seed;
	logic   loaded;

	dmem_subsys #(
		.RAM_ADDR_W (10),
		.REQ_DEPTH  (REQ_DEPTH),
		.RSP_DEPTH  (RSP_DEPTH)
	) dmem_subsys_i (
		.clk            (clk),
		.nrst           (nrst),
		.dm_write       (dm_write),
		.data_addr      (data_addr),
		.data_in        (data_in),
		.data_out       (data_out),
		.btn            (btn),
		.sw             (sw),
		.led            (led),
		.con_req_valid  (con_req_valid),
		.con_req        (con_req),
		.con_req_credit (con_req_credit),
		.con_rsp_valid  (con_rsp_valid),
		.con_rsp        (con_rsp),
		.con_rsp_credit (con_rsp_credit)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	function automatic int op_code(input string s);
		case (s)
			"cw": return OP_CW;
			"cr": return OP_CR;
			"nw": return OP_NW;
			"nr": return OP_NR;
			"io": return OP_IO;
			"hold": return OP_HOLD;
			"rel": return OP_REL;
			"quiet": return OP_QUIET;
			"sync": return OP_SYNC;
			"cred": return OP_CRED;
			default: return 15;
		endcase
	endfunction

	// lines starting with # are column notes
	task automatic load_cases();
		integer fd;
		string line;
		string op;
		logic [31:0] a, s, d, e;
		step_t st;
		fd = $fopen("dmem_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open dmem_cases.txt");
			n_fail++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line[0] != "#" &&
					$sscanf(line, "%s %h %h %h %h", op, a, s, d, e) == 5) begin
				st.op = 4'(op_code(op));
				st.addr = a[10:0];
				st.strb = s[3:0];
				st.data = d;
				st.exp = e;
				steps.push_back(st);
				step_ops.push_back(op);
			end
		end
		$fclose(fd);
	endtask

	// requester side, one credit per request
	task automatic send_req(input strobe_t we, input con_addr_t addr, input word_t data);
		int waited;
		int idle;
		waited = 0;
		while (req_credits == 0) begin
			if (waited == WAIT_LIMIT) begin
				$display("no request credit came back within %0d cycles", WAIT_LIMIT);
				n_fail++;
				return;
			end
			@(posedge clk);
			#1;
			waited++;
		end
		con_req.we = we;
		con_req.addr = addr;
		con_req.data = data;
		con_req_valid = 1'b1;
		req_credits--;
		@(posedge clk);
		#1;
		con_req_valid = 1'b0;
		// random gap before the next request
		idle = $random(seed) & 3;
		repeat (idle) begin
			@(posedge clk);
			#1;
		end
	endtask

	// all request credits home and only `left` responses still due
	task automatic wait_settled(input int left);
		int waited;
		waited = 0;
		while (!(req_credits == REQ_DEPTH && exp_rsp.size() == left)) begin
			if (waited == WAIT_LIMIT) begin
				$display("controller did not settle within %0d cycles", WAIT_LIMIT);
				n_fail++;
				return;
			end
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	task automatic run_step(input step_t st);
		case (int'(st.op))
			OP_CW: begin
				dm_write = st.strb;
				data_addr = st.addr;
				data_in = st.data;
				@(posedge clk);
				#1;
				dm_write = '0;
			end
			OP_CR: begin
				dm_write = '0;
				data_addr = st.addr;
				@(posedge clk);
				#1;
				check("core read", data_out, st.exp);
				if (st.addr == IO_LED) begin
					check("led pins", {28'h0, led}, {28'h0, st.exp[3:0]});
				end
			end
			OP_NW: send_req(st.strb, st.addr[9:0], st.data);
			OP_NR: begin
				exp_rsp.push_back(st.exp);
				send_req('0, st.addr[9:0], '0);
			end
			OP_IO: begin
				btn = st.addr[3:0];
				sw = st.strb[2:0];
				@(posedge clk);
				#1;
			end
			OP_HOLD: hold_credits = 1'b1;
			OP_REL: hold_credits = 1'b0;
			OP_QUIET: begin
				repeat (int'(st.addr)) begin
					@(posedge clk);
					#1;
					check("response while credits withheld", {31'h0, con_rsp_valid}, 0);
				end
			end
			OP_SYNC: wait_settled(int'(st.addr));
			OP_CRED: check("request credit count", req_credits, {21'h0, st.addr});
			default: begin
				$display("unknown op in the case file");
				n_fail++;
			end
		endcase
	endtask

	// response consumer and request credit counter
	always @(posedge clk) begin
		logic give;
		if (nrst && con_rsp_valid) begin
			if (exp_rsp.size() == 0) begin
				$display("controller sent a response nobody asked for: %h", con_rsp);
				n_fail++;
			end else begin
				check("controller response", con_rsp, exp_rsp.pop_front());
			end
			owed++;
		end
		if (nrst && con_req_credit) begin
			req_credits++;
			check("request credits within depth", 32'(req_credits <= REQ_DEPTH), 1);
		end
		give = nrst && !hold_credits && (owed > 0);
		#1;
		con_rsp_credit = give;
		if (give) begin
			owed--;
		end
	end

	initial begin
		int fails_before;
		nrst = 1'b0;
		dm_write = '0;
		data_addr = '0;
		data_in = '0;
		btn = '0;
		sw = '0;
		con_req_valid = 1'b0;
		con_req = '0;
		con_rsp_credit = 1'b0;
		hold_credits = 1'b0;
		owed = 0;
		req_credits = REQ_DEPTH;
		n_pass = 0;
		n_fail = 0;
		seed = 32'hee95;
		loaded = 1'b0;
		load_cases();
		loaded = 1'b1;

		repeat (3) @(posedge clk);
		#1;
		nrst = 1'b1;
		fails_before = n_fail;
		check("led after reset", {28'h0, led}, 0);
		check("data_out after reset", data_out, 0);
		check("rsp valid after reset", {31'h0, con_rsp_valid}, 0);
		check("req credit after reset", {31'h0, con_req_credit}, 0);
		repeat (2) @(posedge clk);
		#1;
		check("no credits returned after reset", req_credits, REQ_DEPTH);
		$display("test reset: %s", (n_fail == fails_before) ? "ok" : "failed");

		foreach (steps[i]) begin
			fails_before = n_fail;
			run_step(steps[i]);
			$display("case %0d %s %h: %s", i, step_ops[i], steps[i].addr,
				(n_fail == fails_before) ? "ok" : "failed");
		end
		wait_settled(0);

		$display("checks passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// run length bound from the case count
	initial begin
		wait (loaded);
		repeat ((steps.size() + 1) * 50) @(posedge clk);
		$display("timeout: run exceeded %0d cycles", (steps.size() + 1) * 50);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dmem_cases.txt ====
# columns: op addr strobe data expected, all hex
# cw/cr core, nw/nr controller, io btn=addr sw=strobe, quiet/sync/cred count in addr
cw 010 f 11223344 0
cr 010 0 0 11223344
cw 010 3 aaaabbbb 0
cr 010 0 0 1122bbbb
cw 010 c ccccdddd 0
cr 010 0 0 ccccbbbb
cw 010 1 000000ee 0
cw 010 4 00550000 0
cr 010 0 0 cc55bbee
cw 011 f 01020304 0
cw 011 8 7f000000 0
cw 011 2 0000a500 0
cr 011 0 0 7f02a504
cw 010 5 ffffffff 0
cw 010 7 ffffffff 0
cr 010 0 0 cc55bbee
cr 500 0 0 00000000
cw 3ff f deadbeef 0
cw 403 f 12345678 0
cr 403 0 0 00000000
cr 3ff 0 0 deadbeef
io 9 5 0 0
cr 400 0 0 00000009
cr 401 0 0 00000005
cr 402 0 0 00000000
cw 402 f a5a5a5a3 0
cr 402 0 0 a5a5a5a3
cw 402 1 0000000c 0
cw 402 c 12340000 0
cr 402 0 0 1234a50c
cw 402 6 ffffffff 0
cw 402 2 00007700 0
cr 402 0 0 1234770c
nw 020 f cafef00d 0
sync 0 0 0 0
cr 020 0 0 cafef00d
cw 021 f 0badc0de 0
nr 021 0 0 0badc0de
nw 020 3 00001234 0
nw 020 5 ffffffff 0
nr 020 0 0 cafe1234
sync 0 0 0 0
cr 020 0 0 cafe1234
hold 0 0 0 0
nr 010 0 0 cc55bbee
nr 011 0 0 7f02a504
nr 020 0 0 cafe1234
nr 021 0 0 0badc0de
sync 0 0 0 0
nr 3ff 0 0 deadbeef
nr 010 0 0 cc55bbee
nr 011 0 0 7f02a504
nr 020 0 0 cafe1234
nr 021 0 0 0badc0de
quiet a 0 0 0
cred 3 0 0 0
rel 0 0 0 0
sync 0 0 0 0

// ==== all.f ====
dmem_pkg.sv
sync_fifo.sv
dual_port_ram.sv
fpga_io_regs.sv
datamem.sv
con_port.sv
dmem_subsys.sv
tb_dmem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dmem_subsys -f all.f

./obj_dir/Vtb_dmem_subsys > sim.log 2>&1 || {
	cat sim.log
	echo "simulator exited with an error"
	exit 1
}
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
